// ==== blackjack.f ====
+incdir+.
blackjack_pkg.sv
card_deck.sv
hand_scorer.sv
round_sequencer.sv
outcome_judge.sv
blackjack_top.sv
blackjack_asserts.sv
blackjack_tb.sv

// ==== blackjack_asserts.sv ====
/*
 * Concurrent checks bound into the blackjack top level
 * Deck busy after a request, verdict and house stand while done
 * Hand sums change only on their own add or on a clear
 */
`include "blackjack_defs.svh"

module blackjack_asserts import blackjack_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         req,
    input logic         ready,
    input logic         player_add,
    input logic         house_add,
    input logic         done,
    input game_result_t result,
    input hand_sum_t    player_sum,
    input hand_sum_t    house_sum
);
    timeunit 1ns;
    timeprecision 1ps;

    // Deck goes busy the cycle after a request
    ready_falls: assert property (@(posedge clk) disable iff (rst) req |=> !ready)
        else $error("deck ready stayed high after a request");

    // A finished round carries a verdict, and the house has stood
    done_has_result: assert property (@(posedge clk) disable iff (rst)
        done |-> (result != RESULT_NONE) && (house_sum >= hand_sum_t'(`BJ_HOUSE_STAND)))
        else $error("done is high with no verdict or with the house below its stand value");

    // A sum moves only on its own add, or back to zero on a clear
    player_sum_moves: assert property (@(posedge clk) disable iff (rst)
        $changed(player_sum) |-> $past(player_add) || (player_sum == '0))
        else $error("player sum changed without a card for the player");

    house_sum_moves: assert property (@(posedge clk) disable iff (rst)
        $changed(house_sum) |-> $past(house_add) || (house_sum == '0))
        else $error("house sum changed without a card for the house");

endmodule

bind blackjack_top blackjack_asserts blackjack_asserts_i (
    .clk        (clk),
    .rst        (rst),
    .req        (deal.req),
    .ready      (deal.ready),
    .player_add (hands[`BJ_PLAYER_IDX].add),
    .house_add  (hands[`BJ_HOUSE_IDX].add),
    .done       (done),
    .result     (result),
    .player_sum (player_sum),
    .house_sum  (house_sum)
);

// ==== blackjack_defs.svh ====
/*
 * Shared widths and thresholds of the blackjack round
 * Card, sum and seed widths, rule thresholds and LFSR feedback mask
 * Hand indices into the array of hand interfaces
 */
`ifndef BLACKJACK_DEFS_SVH
`define BLACKJACK_DEFS_SVH

// Width of a hand sum, large enough for a bust hand
`define BJ_SUM_W 6
// Width of a card rank, ranks 1 to 13
`define BJ_RANK_W 4
// Width of the seed and of the LFSR in the deck
`define BJ_SEED_W 16

// Player turn ends at this sum, above it is a bust
`define BJ_BLACKJACK 21
// House stops drawing at this sum
`define BJ_HOUSE_STAND 17

// Galois feedback mask, right-shifting LFSR
`define BJ_LFSR_TAPS 16'hB400
// Highest valid rank, faces count as the face value
`define BJ_RANK_MAX 13
`define BJ_FACE_VALUE 10

// Hands in the round and their slots
`define BJ_NUM_HANDS 2
`define BJ_PLAYER_IDX 0
`define BJ_HOUSE_IDX 1
// Cards dealt before the player turn
`define BJ_DEAL_CARDS 4

`endif

// ==== blackjack_pkg.sv ====
/*
 * Blackjack types: card rank, hand sum, verdict and sequencer phase
 * deal_if: shuffle and card handshake between sequencer and deck
 * hand_if: clear, add and sum of one hand
 */
`include "blackjack_defs.svh"

package blackjack_pkg;

    typedef logic [`BJ_RANK_W-1:0] card_rank_t;
    typedef logic [`BJ_SUM_W-1:0] hand_sum_t;

    // Verdict of the judge, NONE until a round is decided
    typedef enum logic [1:0] {
        RESULT_NONE,
        RESULT_PLAYER,
        RESULT_HOUSE,
        RESULT_DRAW
    } game_result_t;

    // Sequencer states
    typedef enum logic [3:0] {
        PHASE_IDLE,
        PHASE_SHUFFLE,
        PHASE_REQUEST,
        PHASE_WAIT,
        PHASE_PLAYER,
        PHASE_HOUSE,
        PHASE_DECIDE,
        PHASE_FINISHED
    } round_phase_t;

endpackage

interface deal_if import blackjack_pkg::*; ();
    logic                  shuffle;
    logic [`BJ_SEED_W-1:0] seed;
    logic                  req;
    logic                  ready;
    card_rank_t            rank;

    modport ctrl (output shuffle, seed, req, input ready, rank);
    modport deck (input shuffle, seed, req, output ready, rank);
endinterface

interface hand_if import blackjack_pkg::*; ();
    logic       clear;
    logic       add;
    card_rank_t card_rank;
    hand_sum_t  sum;

    modport ctrl (output clear, add, input sum);
    modport scorer (input clear, add, card_rank, output sum);
    modport judge (input sum);
endinterface

// ==== blackjack_tb.sv ====
/*
 * Testbench of the blackjack round
 * Table of seeds and hit counts, applied in a loop
 * Reference model of the LFSR deck, card values and round rules
 * Cross-row checks for seed zero and for ignored input pulses
 */
`include "blackjack_defs.svh"

module blackjack_tb import blackjack_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FIXED  = 11;
    localparam int NUM_ROWS   = 20;
    // Cycles allowed for any single wait on the DUT
    localparam int WAIT_LIMIT = 200;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  hit;
    logic                  stand;
    logic [`BJ_SEED_W-1:0] seed;
    logic                  done;
    game_result_t          result;
    hand_sum_t             player_sum;
    hand_sum_t             house_sum;

    // Stimulus table
    logic [`BJ_SEED_W-1:0] row_seed [NUM_ROWS];
    int                    row_hits [NUM_ROWS];
    bit                    row_noise [NUM_ROWS];
    string                 row_name [NUM_ROWS];
    // Final outputs per row, compared across rows at the end
    int                    got_player [NUM_ROWS];
    int                    got_house [NUM_ROWS];
    game_result_t          got_result [NUM_ROWS];

    int                    errors;
    int                    checks;
    logic [`BJ_SEED_W-1:0] model_lfsr;

    blackjack_top blackjack_top_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .hit        (hit),
        .stand      (stand),
        .seed       (seed),
        .done       (done),
        .result     (result),
        .player_sum (player_sum),
        .house_sum  (house_sum)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog, 400 cycles per table row plus reset
    initial begin
        repeat (8 + NUM_ROWS * 400) @(posedge clk);
        $display("Timeout: the rounds did not finish within the cycle budget");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Next card value of the model deck
    // Steps until the low nibble is a rank 1 to 13, faces count 10
    function automatic int draw_value();
        logic [3:0] r;
        r = 4'd0;
        while (r == 4'd0 || r > 4'd13) begin
            if (model_lfsr[0]) begin
                model_lfsr = (model_lfsr >> 1) ^ `BJ_LFSR_TAPS;
            end else begin
                model_lfsr = model_lfsr >> 1;
            end
            r = model_lfsr[3:0];
        end
        return (r > 4'd10) ? 10 : int'(r);
    endfunction

    // Whole round in the model: deal, player hits, house to 17, verdict
    task automatic model_round(input logic [`BJ_SEED_W-1:0] s, input int hits,
                               output int exp_p, output int exp_h,
                               output game_result_t exp_r);
        model_lfsr = (s == '0) ? `BJ_SEED_W'(1) : s;
        exp_p = draw_value();
        exp_h = draw_value();
        exp_p += draw_value();
        exp_h += draw_value();
        // Hits stop counting once the player holds 21 or more
        for (int i = 0; i < hits && exp_p < `BJ_BLACKJACK; i++) begin
            exp_p += draw_value();
        end
        // House draws even after a player bust
        while (exp_h < `BJ_HOUSE_STAND) begin
            exp_h += draw_value();
        end
        if (exp_p > `BJ_BLACKJACK) begin
            exp_r = RESULT_HOUSE;
        end else if (exp_h > `BJ_BLACKJACK) begin
            exp_r = RESULT_PLAYER;
        end else if (exp_p > exp_h) begin
            exp_r = RESULT_PLAYER;
        end else if (exp_p < exp_h) begin
            exp_r = RESULT_HOUSE;
        end else begin
            exp_r = RESULT_DRAW;
        end
    endtask

    task automatic set_row(input int n, input logic [`BJ_SEED_W-1:0] s, input int h,
                           input bit z, input string name);
        row_seed[n]  = s;
        row_hits[n]  = h;
        row_noise[n] = z;
        row_name[n]  = name;
    endtask

    task automatic fill_table();
        set_row(0, 16'h0001, 0, 1'b0, "stand_seed_one");
        set_row(1, 16'h0000, 0, 1'b0, "stand_seed_zero");
        set_row(2, 16'hACE1, 0, 1'b0, "stand_ace1");
        set_row(3, 16'h1234, 8, 1'b0, "hit_to_21");
        set_row(4, 16'hBEEF, 8, 1'b0, "hit_many");
        set_row(5, 16'h7A5C, 1, 1'b0, "one_hit");
        set_row(6, 16'h0F0F, 2, 1'b0, "two_hits");
        set_row(7, 16'h1234, 8, 1'b1, "noise_hit_to_21");
        set_row(8, 16'hACE1, 0, 1'b1, "noise_stand");
        set_row(9, 16'hFFFF, 3, 1'b0, "three_hits");
        set_row(10, 16'h5555, 8, 1'b0, "hit_many_b");
        // Remaining rows from the seeded random stream
        for (int n = NUM_FIXED; n < NUM_ROWS; n++) begin
            set_row(n, `BJ_SEED_W'($urandom()), int'($urandom() % 5),
                    ($urandom() % 2) == 1, $sformatf("random_%0d", n - NUM_FIXED));
        end
    endtask

    // One round: start, deal with optional noise, hits, stand, checks
    task automatic run_row(input int n);
        int           exp_p;
        int           exp_h;
        int           prev;
        int           cycles;
        int           house_changes;
        game_result_t exp_r;
        model_round(row_seed[n], row_hits[n], exp_p, exp_h, exp_r);
        seed  = row_seed[n];
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // Shuffle clears both hands on this edge
        @(negedge clk);
        prev          = 0;
        cycles        = 0;
        house_changes = 0;
        // Second house card ends the deal
        while (house_changes < 2 && cycles < WAIT_LIMIT) begin
            hit   = row_noise[n] && (cycles % 3 == 0);
            stand = row_noise[n] && (cycles % 3 == 1);
            start = row_noise[n] && (cycles % 7 == 2);
            @(negedge clk);
            cycles++;
            if (int'(house_sum) != prev) begin
                house_changes++;
                prev = int'(house_sum);
            end
        end
        hit   = 1'b0;
        stand = 1'b0;
        start = 1'b0;
        if (house_changes < 2) begin
            errors++;
            $display("Row %s: the opening deal did not complete", row_name[n]);
            return;
        end
        // Each hit waits for its card, or for done once hits are refused
        for (int i = 0; i < row_hits[n] && !done; i++) begin
            prev = int'(player_sum);
            hit  = 1'b1;
            @(negedge clk);
            hit    = 1'b0;
            cycles = 0;
            while (int'(player_sum) == prev && !done && cycles < WAIT_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
        end
        if (!done) begin
            stand = 1'b1;
            @(negedge clk);
            stand = 1'b0;
        end
        cycles = 0;
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("Row %s: done never rose after the player turn", row_name[n]);
            return;
        end
        got_player[n] = int'(player_sum);
        got_house[n]  = int'(house_sum);
        got_result[n] = result;
        checks += 3;
        if (int'(player_sum) != exp_p) begin
            errors++;
            $display("FAILED %s player_sum: expected %0d, actual %0d",
                     row_name[n], exp_p, player_sum);
        end
        if (int'(house_sum) != exp_h) begin
            errors++;
            $display("FAILED %s house_sum: expected %0d, actual %0d",
                     row_name[n], exp_h, house_sum);
        end
        if (result != exp_r) begin
            errors++;
            $display("FAILED %s result: expected %s, actual %s",
                     row_name[n], exp_r.name(), result.name());
        end
    endtask

    // Two rows that must end in the same round
    task automatic compare_rows(input int a, input int b, input string name);
        checks++;
        if (got_player[a] != got_player[b] || got_house[a] != got_house[b]
            || got_result[a] != got_result[b]) begin
            errors++;
            $display("FAILED %s: expected %0d/%0d/%s, actual %0d/%0d/%s", name,
                     got_player[a], got_house[a], got_result[a].name(),
                     got_player[b], got_house[b], got_result[b].name());
        end
    endtask

    initial begin
        rst    = 1'b1;
        start  = 1'b0;
        hit    = 1'b0;
        stand  = 1'b0;
        seed   = '0;
        errors = 0;
        checks = 0;
        void'($urandom(9));
        fill_table();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        // Idle state after reset
        checks++;
        if (done !== 1'b0 || result !== RESULT_NONE || player_sum !== '0
            || house_sum !== '0) begin
            errors++;
            $display("FAILED reset_state: expected 0/RESULT_NONE/0/0, actual %0b/%s/%0d/%0d",
                     done, result.name(), player_sum, house_sum);
        end
        for (int n = 0; n < NUM_ROWS; n++) begin
            run_row(n);
        end
        compare_rows(0, 1, "seed_zero_vs_one");
        compare_rows(2, 8, "noise_stand_vs_clean");
        compare_rows(3, 7, "noise_hits_vs_clean");
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== blackjack_top.sv ====
/*
 * Blackjack round top level
 * Deck, sequencer and judge joined by the deal and hand interfaces
 * Two hand scorers in a generate loop, player first, house second
 */
`include "blackjack_defs.svh"

module blackjack_top import blackjack_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  start,
    input logic                  hit,
    input logic                  stand,
    input logic [`BJ_SEED_W-1:0] seed,
    output logic                 done,
    output game_result_t         result,
    output hand_sum_t            player_sum,
    output hand_sum_t            house_sum
);

    deal_if deal ();
    hand_if hands [`BJ_NUM_HANDS] ();
    logic   decide;

    card_deck card_deck_i (
        .clk  (clk),
        .rst  (rst),
        .deal (deal)
    );

    // Every hand sees the rank registered by the deck
    for (genvar i = 0; i < `BJ_NUM_HANDS; i++) begin : g_hand
        assign hands[i].card_rank = deal.rank;

        hand_scorer hand_scorer_i (
            .clk  (clk),
            .rst  (rst),
            .hand (hands[i])
        );
    end

    round_sequencer round_sequencer_i (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .hit    (hit),
        .stand  (stand),
        .seed   (seed),
        .deal   (deal),
        .hands  (hands),
        .decide (decide)
    );

    outcome_judge outcome_judge_i (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .decide (decide),
        .hands  (hands),
        .result (result),
        .done   (done)
    );

    assign player_sum = hands[`BJ_PLAYER_IDX].sum;
    assign house_sum  = hands[`BJ_HOUSE_IDX].sum;

endmodule

// ==== card_deck.sv ====
/*
 * Seeded pseudo-random card source
 * 16-bit Galois LFSR stepped until the low bits form a rank 1 to 13
 * Request/ready handshake towards the round sequencer
 */
`include "blackjack_defs.svh"

module card_deck import blackjack_pkg::*; (
    input logic   clk,
    input logic   rst,
    deal_if.deck  deal
);

    logic [`BJ_SEED_W-1:0] lfsr;
    logic [`BJ_SEED_W-1:0] lfsr_next;
    logic                  busy;
    card_rank_t            candidate;
    logic                  accept;

    // One right shift, feedback mask applied when a one falls out
    always_comb begin
        lfsr_next = lfsr >> 1;
        if (lfsr[0]) begin
            lfsr_next = lfsr_next ^ `BJ_LFSR_TAPS;
        end
    end

    // Rank candidate taken from the stepped value
    assign candidate = lfsr_next[`BJ_RANK_W-1:0];
    assign accept = (candidate != '0) && (candidate <= card_rank_t'(`BJ_RANK_MAX));

    // Ready is low from the cycle after req until a card is found
    assign deal.ready = !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= `BJ_SEED_W'(1);
            busy <= 1'b0;
        end else if (deal.shuffle) begin
            // All-zero state would lock the LFSR
            if (deal.seed == '0) begin
                lfsr <= `BJ_SEED_W'(1);
            end else begin
                lfsr <= deal.seed;
            end
            busy <= 1'b0;
        end else if (busy) begin
            // One step per cycle while searching
            lfsr <= lfsr_next;
            if (accept) begin
                busy <= 1'b0;
            end
        end else if (deal.req) begin
            busy <= 1'b1;
        end
    end

    // Rank holds from acceptance until the next request completes
    always_ff @(posedge clk) begin
        if (busy && accept && !deal.shuffle) begin
            deal.rank <= candidate;
        end
    end

endmodule

// ==== hand_scorer.sv ====
/*
 * Sum of one hand
 * Maps a rank to its card value, faces count ten
 * Cleared at round start, one card added per add pulse
 */
`include "blackjack_defs.svh"

module hand_scorer import blackjack_pkg::*; (
    input logic     clk,
    input logic     rst,
    hand_if.scorer  hand
);

    hand_sum_t card_value;
    hand_sum_t sum_q;

    // Rank 1 counts one, 2 to 10 count their rank
    // Jack, queen and king count ten
    always_comb begin
        if (hand.card_rank > card_rank_t'(`BJ_FACE_VALUE)) begin
            card_value = hand_sum_t'(`BJ_FACE_VALUE);
        end else begin
            card_value = hand_sum_t'(hand.card_rank);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_q <= '0;
        end else if (hand.clear) begin
            // New round
            sum_q <= '0;
        end else if (hand.add) begin
            // Rank is stable here, the deck registered it a cycle earlier
            sum_q <= sum_q + card_value;
        end
    end

    // Worst case is 20 plus a face, fits in the sum width
    assign hand.sum = sum_q;

endmodule

// ==== outcome_judge.sv ====
/*
 * Verdict of the round
 * Compares the player and house sums and registers the result on decide
 * Player bust loses first, then house bust, then the larger sum
 */
`include "blackjack_defs.svh"

module outcome_judge import blackjack_pkg::*; (
    input logic          clk,
    input logic          rst,
    input logic          start,
    input logic          decide,
    hand_if.judge        hands [`BJ_NUM_HANDS],
    output game_result_t result,
    output logic         done
);

    hand_sum_t    player_sum;
    hand_sum_t    house_sum;
    game_result_t verdict;

    assign player_sum = hands[`BJ_PLAYER_IDX].sum;
    assign house_sum  = hands[`BJ_HOUSE_IDX].sum;

    always_comb begin
        if (player_sum > hand_sum_t'(`BJ_BLACKJACK)) begin
            // Player bust loses whatever the house holds
            verdict = RESULT_HOUSE;
        end else if (house_sum > hand_sum_t'(`BJ_BLACKJACK)) begin
            verdict = RESULT_PLAYER;
        end else if (player_sum > house_sum) begin
            verdict = RESULT_PLAYER;
        end else if (player_sum < house_sum) begin
            verdict = RESULT_HOUSE;
        end else begin
            verdict = RESULT_DRAW;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= RESULT_NONE;
            done   <= 1'b0;
        end else if (decide) begin
            // Decide wins, a start in this cycle is ignored by the sequencer
            result <= verdict;
            done   <= 1'b1;
        end else if (start) begin
            result <= RESULT_NONE;
            done   <= 1'b0;
        end
    end

endmodule

// ==== round_sequencer.sv ====
/*
 * Round sequencer FSM
 * Shuffle, four dealt cards, player turn, house turn, verdict request
 * One shared request/wait pair serves every card drawn
 */
`include "blackjack_defs.svh"

module round_sequencer import blackjack_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  start,
    input logic                  hit,
    input logic                  stand,
    input logic [`BJ_SEED_W-1:0] seed,
    deal_if.ctrl                 deal,
    hand_if.ctrl                 hands [`BJ_NUM_HANDS],
    output logic                 decide
);

    round_phase_t phase;
    // Cards dealt so far in the opening deal
    logic [2:0]   deal_cnt;
    // Destination of the card in flight
    logic         to_house;
    logic         dealing;
    logic         card_in;
    logic         player_done;
    logic         house_draws;

    assign dealing = (deal_cnt < 3'(`BJ_DEAL_CARDS));
    // Ready back high while waiting means the card is in
    assign card_in = (phase == PHASE_WAIT) && deal.ready;

    // Player turn ends at 21 or more, bust itself is judged later
    assign player_done =
        (hands[`BJ_PLAYER_IDX].sum >= hand_sum_t'(`BJ_BLACKJACK));
    assign house_draws =
        (hands[`BJ_HOUSE_IDX].sum < hand_sum_t'(`BJ_HOUSE_STAND));

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= PHASE_IDLE;
            deal_cnt <= '0;
            to_house <= 1'b0;
        end else begin
            case (phase)
                PHASE_IDLE, PHASE_FINISHED: begin
                    // Start is only taken between rounds
                    if (start) begin
                        phase <= PHASE_SHUFFLE;
                    end
                end
                PHASE_SHUFFLE: begin
                    // Deal order is player, house, player, house
                    deal_cnt <= '0;
                    to_house <= 1'b0;
                    phase    <= PHASE_REQUEST;
                end
                PHASE_REQUEST: begin
                    if (deal.ready) begin
                        phase <= PHASE_WAIT;
                    end
                end
                PHASE_WAIT: begin
                    if (deal.ready) begin
                        if (dealing) begin
                            deal_cnt <= deal_cnt + 3'd1;
                            to_house <= !to_house;
                            // Last of the four dealt cards hands over to the player
                            if (deal_cnt == 3'(`BJ_DEAL_CARDS - 1)) begin
                                phase <= PHASE_PLAYER;
                            end else begin
                                phase <= PHASE_REQUEST;
                            end
                        end else if (to_house) begin
                            phase <= PHASE_HOUSE;
                        end else begin
                            phase <= PHASE_PLAYER;
                        end
                    end
                end
                PHASE_PLAYER: begin
                    // Sum check wins over a hit in the same cycle
                    if (player_done || stand) begin
                        phase <= PHASE_HOUSE;
                    end else if (hit) begin
                        to_house <= 1'b0;
                        phase    <= PHASE_REQUEST;
                    end
                end
                PHASE_HOUSE: begin
                    // House draws to 17 even after a player bust
                    if (house_draws) begin
                        to_house <= 1'b1;
                        phase    <= PHASE_REQUEST;
                    end else begin
                        phase <= PHASE_DECIDE;
                    end
                end
                PHASE_DECIDE: begin
                    phase <= PHASE_FINISHED;
                end
                default: begin
                    phase <= PHASE_IDLE;
                end
            endcase
        end
    end

    // Deck controls
    assign deal.shuffle = (phase == PHASE_SHUFFLE);
    assign deal.seed    = seed;
    // Request only while the deck reports ready
    assign deal.req     = (phase == PHASE_REQUEST) && deal.ready;

    // Clear every hand with the shuffle, add goes to one hand only
    for (genvar i = 0; i < `BJ_NUM_HANDS; i++) begin : g_hand_ctrl
        assign hands[i].clear = (phase == PHASE_SHUFFLE);
        assign hands[i].add   = card_in && (to_house == (i == `BJ_HOUSE_IDX));
    end

    assign decide = (phase == PHASE_DECIDE);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the blackjack round testbench
# Build output goes to build.log, simulation output to sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f blackjack.f --top-module blackjack_tb \
    -o blackjack_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/blackjack_sim > sim.log 2>&1
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "No verdict in sim.log"; exit 1; }
echo "Simulation passed"
